//--- cpu_core.f
+incdir+source
source/cpu_pkg.sv
source/cpu_if.sv
source/register_file.sv
source/fetch_decode.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu_core.sv
verif/cpu_core_tb.sv

//--- run_cpu_core.sh
#!/bin/sh
# compile and run the cpu_core testbench with verilator
set -e
cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir

verilator --binary --timing -j 0 \
  --top-module cpu_core_tb \
  -f cpu_core.f \
  -o cpu_core_sim

# a crashed simulation leaves no pass line, so the log search still fails it
./obj_dir/cpu_core_sim > "$log" 2>&1 || true
cat "$log"

if grep -q "Result: PASSED" "$log"; then
  echo "cpu_core simulation passed"
else
  echo "cpu_core simulation failed"
  exit 1
fi

//--- verif/cpu_testdata.txt
# P byte_addr instr | W reg value | S byte_addr data | T test_name
# values in hex, W and S give the expected trace records in program order
T byte_loads
P 00 A134
W 1 0034
P 02 B112
W 1 1234
P 04 A2FF
W 2 00FF
P 06 B280
W 2 80FF
P 08 A055
P 0A B066
P 0C A3FF
W 3 00FF
P 0E B3FF
W 3 FFFF
P 10 0401
W 4 1234
T alu_independent
P 12 0532
W 5 80FE
P 14 1601
W 6 EDCC
P 16 2712
W 7 92CB
P 18 4810
W 8 1234
P 1A 492F
W 9 8000
P 1C 5A2F
W A FFFF
P 1E 5B20
W B 80FF
P 20 6C10
W C 1234
P 22 6D1F
W D 2468
T forwarding
P 24 0433
W 4 FFFE
P 26 1542
W 5 7EFF
P 28 2645
W 6 8101
P 2A 4764
W 7 1010
P 2C 0776
W 7 9111
P 2E 6878
W 8 1191
P 30 5981
W 9 08C8
T store_load
P 32 9741
S 0000 9111
P 34 984F
S FFFC 1191
P 36 9548
S FFEE 7EFF
P 38 9647
S 000C 8101
P 3A 8B41
W B 9111
P 3C 0C12
W C 9333
P 3E 8D4F
W D 1191
P 40 2EB0
W E 9111
P 42 0FDB
W F A2A2
P 44 8148
W 1 7EFF
P 46 8247
W 2 8101
P 48 0300
W 3 0000
P 4A 1421
W 4 0202
T noop_halt
P 4C 3123
P 4E 7456
P 50 C789
P 52 D1AB
P 54 E2CD
P 56 0544
W 5 0404
P 58 2612
W 6 FFFE
P 5A F000
P 5C 0711

//--- verif/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb
  import cpu_pkg::*;
();

  localparam int IMEM_WORDS = 256;
  localparam int MAX_GROUPS = 8;

  logic     clk;
  logic     reset;
  word_t    instr_addr;
  word_t    instr_data;
  word_t    pc;
  logic     hlt;
  logic     wb_valid;
  reg_idx_t wb_reg;
  word_t    wb_data;
  logic     store_valid;
  word_t    store_addr;
  word_t    store_data;

  // program image and expected traces in program order
  word_t      imem [IMEM_WORDS];
  wb_rec_t    wb_exp [$];
  int         wb_grp [$];
  store_rec_t st_exp [$];
  int         st_grp [$];

  // per test bookkeeping
  string group_name [MAX_GROUPS];
  int    group_left [MAX_GROUPS];
  int    group_errs [MAX_GROUPS];
  bit    group_done [MAX_GROUPS];
  int    group_count = 0;

  int prog_len = 0;
  int errors = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  bit hlt_seen = 1'b0;

  // fetch address expected in the current cycle
  word_t pc_exp = '0;

  cpu_core i_cpu_core (
    .clk         (clk),
    .reset       (reset),
    .instr_addr  (instr_addr),
    .instr_data  (instr_data),
    .pc          (pc),
    .hlt         (hlt),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // instruction memory answers the current pc, a little after the edge
  always @(posedge clk) begin
    #1;
    if ($isunknown(instr_addr)) instr_data = {4'hF, 12'h000};
    else instr_data = imem[instr_addr[8:1]];
  end

  always @(posedge clk) begin
    if (!reset) cycles++;
  end

  task automatic load_testdata(output bit ok);
    int              fd;
    int              code;
    int              cur_group;
    logic [8*32-1:0] tag;
    logic [8*128-1:0] text;
    logic [31:0]     a;
    logic [31:0]     b;
    wb_rec_t         w;
    store_rec_t      s;
    ok = 1'b0;
    cur_group = 0;
    // empty slots decode as hlt, low bits follow the slot index
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {4'hF, 4'h0, 8'(i)};
    end
    fd = $fopen("verif/cpu_testdata.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        tag = '0;
        code = $fscanf(fd, "%s", tag);
        if (code == 1) begin
          if (tag[7:0] == "#") begin
            code = $fgets(text, fd);
          end else if (tag[7:0] == "T" && group_count < MAX_GROUPS) begin
            text = '0;
            code = $fscanf(fd, "%s", text);
            cur_group = group_count;
            group_name[cur_group] = string'(text);
            group_left[cur_group] = 0;
            group_errs[cur_group] = 0;
            group_done[cur_group] = 1'b0;
            group_count++;
          end else if (tag[7:0] == "P") begin
            code = $fscanf(fd, "%h %h", a, b);
            imem[a[8:1]] = b[15:0];
            prog_len++;
          end else if (tag[7:0] == "W") begin
            code = $fscanf(fd, "%h %h", a, b);
            w.rd = a[3:0];
            w.data = b[15:0];
            wb_exp.push_back(w);
            wb_grp.push_back(cur_group);
            group_left[cur_group]++;
          end else if (tag[7:0] == "S") begin
            code = $fscanf(fd, "%h %h", a, b);
            s.addr = a[15:0];
            s.data = b[15:0];
            st_exp.push_back(s);
            st_grp.push_back(cur_group);
            group_left[cur_group]++;
          end else begin
            $display("the test data file holds a line of unknown kind");
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end else begin
      $display("the test data file verif/cpu_testdata.txt could not be opened");
    end
  endtask

  task automatic report_group(input int g);
    if (!group_done[g]) begin
      group_done[g] = 1'b1;
      if (group_errs[g] == 0 && group_left[g] == 0) begin
        $display("test %0s: passed", group_name[g]);
        tests_passed++;
      end else begin
        $display("test %0s: failed with %0d errors and %0d records never seen",
                 group_name[g], group_errs[g], group_left[g]);
        tests_failed++;
      end
    end
  endtask

  // last test stays open until the post-halt window is over
  task automatic record_done(input int g);
    group_left[g]--;
    if (group_left[g] == 0 && g < group_count - 1) report_group(g);
  endtask

  task automatic check_writeback(input wb_rec_t got);
    wb_rec_t exp;
    int      g;
    if (wb_exp.size() == 0) begin
      $display("register write r%0d = %h retired when no more writes were expected",
               got.rd, got.data);
      errors++;
      if (group_count > 0) group_errs[group_count-1]++;
    end else begin
      exp = wb_exp.pop_front();
      g = wb_grp.pop_front();
      if (got !== exp) begin
        $display("Mismatch at %0t: test %0s register write r%0d = %h, expected r%0d = %h",
                 $time, group_name[g], got.rd, got.data, exp.rd, exp.data);
        errors++;
        group_errs[g]++;
      end
      record_done(g);
    end
  endtask

  task automatic check_store(input store_rec_t got);
    store_rec_t exp;
    int         g;
    if (st_exp.size() == 0) begin
      $display("a store of %h to %h appeared when no more stores were expected",
               got.data, got.addr);
      errors++;
      if (group_count > 0) group_errs[group_count-1]++;
    end else begin
      exp = st_exp.pop_front();
      g = st_grp.pop_front();
      if (got !== exp) begin
        $display("Mismatch at %0t: test %0s store %h to %h, expected %h to %h",
                 $time, group_name[g], got.data, got.addr, exp.data, exp.addr);
        errors++;
        group_errs[g]++;
      end
      record_done(g);
    end
  endtask

  // one fetch address output against the expected pc
  task automatic check_pc(input word_t got, input word_t exp, input string name);
    if (got !== exp) begin
      $display("Mismatch at %0t: %0s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // traces are sampled mid-cycle
  // hlt is judged before this cycle's records are taken off the queues
  always @(negedge clk) begin
    if (!reset) begin
      if (hlt === 1'b1 && !hlt_seen) begin
        hlt_seen = 1'b1;
        if (wb_exp.size() + st_exp.size() != 0) begin
          $display("hlt rose while %0d register writes and %0d stores were still due",
                   wb_exp.size(), st_exp.size());
          errors++;
          if (group_count > 0) group_errs[group_count-1]++;
        end
      end
      check_pc(pc, pc_exp, "pc");
      check_pc(instr_addr, pc_exp, "instr_addr");
      // pc steps by two and holds once a hlt is fetched
      if (imem[pc_exp[8:1]][15:12] != 4'hF) pc_exp = pc_exp + 16'd2;
      if (wb_valid) check_writeback('{rd: wb_reg, data: wb_data});
      if (store_valid) check_store('{addr: store_addr, data: store_data});
    end
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    wait (cycles >= cycle_limit);
    $display("timeout, the processor did not halt within %0d cycles", cycle_limit);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    bit loaded;
    reset = 1'b1;
    instr_data = '0;
    load_testdata(loaded);
    cycle_limit = 4 * prog_len + 40;
    if (loaded) begin
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      if (hlt !== 1'b0 || wb_valid !== 1'b0 || store_valid !== 1'b0) begin
        $display("hlt or a trace valid was still high right after reset");
        errors++;
      end
      wait (hlt_seen);
      // anything retiring after the halt is caught here
      repeat (10) @(negedge clk);
    end else begin
      errors++;
    end
    for (int g = 0; g < group_count; g++) begin
      report_group(g);
    end
    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- source/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // instruction port
  output word_t    instr_addr,
  input  word_t    instr_data,
  output word_t    pc,
  output logic     hlt,
  // retire trace
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output word_t    wb_data,
  // store trace
  output logic     store_valid,
  output word_t    store_addr,
  output word_t    store_data
);

  ex_bus_if  ex_bus ();
  mem_bus_if mem_bus ();
  wb_bus_if  wb_bus ();

  fetch_decode i_fetch_decode (
    .clk        (clk),
    .reset      (reset),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .pc         (pc),
    .wb         (wb_bus),
    .ex         (ex_bus)
  );

  execute_stage i_execute_stage (
    .clk   (clk),
    .reset (reset),
    .ex    (ex_bus),
    .fwd   (wb_bus),
    .mem   (mem_bus)
  );

  result_stage i_result_stage (
    .clk   (clk),
    .reset (reset),
    .mem   (mem_bus),
    .wb    (wb_bus),
    .hlt   (hlt)
  );

  // only real register writes show on the retire trace
  assign wb_valid = wb_bus.valid && wb_bus.reg_write;
  assign wb_reg   = wb_bus.rd;
  assign wb_data  = wb_bus.data;

  // store trace taps the execute/result slot
  assign store_valid = mem_bus.valid && mem_bus.ctrl.mem_write;
  assign store_addr  = mem_bus.alu_result;
  assign store_data  = mem_bus.store_data;

endmodule

//--- source/result_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module result_stage
  import cpu_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  mem_bus_if.dst mem,
  wb_bus_if.src  wb,
  output logic   hlt
);

  localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

  word_t              dmem [`CPU_DMEM_WORDS];
  logic [DMEM_AW-1:0] dmem_idx;
  logic               store_en;
  word_t              load_data;
  word_t              result;

  // byte address to word index
  assign dmem_idx = mem.alu_result[DMEM_AW:1];
  assign store_en = mem.valid && mem.ctrl.mem_write;

  always_ff @(posedge clk) begin
    if (store_en) dmem[dmem_idx] <= mem.store_data;
  end

  // asynchronous read
  assign load_data = dmem[dmem_idx];
  assign result    = mem.ctrl.mem_read ? load_data : mem.alu_result;

  // result/writeback slot
  always_ff @(posedge clk) begin
    if (reset) wb.valid <= 1'b0;
    else wb.valid <= mem.valid;
  end

  always_ff @(posedge clk) begin
    wb.reg_write <= mem.ctrl.reg_write;
    wb.rd        <= mem.rd;
    wb.data      <= result;
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (reset) hlt <= 1'b0;
    else if (mem.valid && mem.ctrl.halt) hlt <= 1'b1;
  end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  ex_bus_if.dst     ex,
  wb_bus_if.forward fwd,
  mem_bus_if.src    mem
);

  localparam int SHAMT_W = $clog2(`CPU_DATA_W);

  logic                      mem_fwd_ok;
  logic                      wb_fwd_ok;
  logic                      rs_mem_hit;
  logic                      rt_mem_hit;
  logic                      rs_wb_hit;
  logic                      rt_wb_hit;
  word_t                     rs_val;
  word_t                     rt_val;
  word_t                     op_a;
  word_t                     op_b;
  logic [SHAMT_W-1:0]        shamt;
  logic [2*`CPU_DATA_W-1:0]  rot_wide;
  word_t                     alu_out;

  // own result register holds the previous instruction
  // a load there has no data yet and is skipped
  assign mem_fwd_ok = mem.valid && mem.ctrl.reg_write && !mem.ctrl.mem_read &&
                      (mem.rd != '0);

  // writeback bus holds the instruction two ahead
  assign wb_fwd_ok = fwd.valid && fwd.reg_write && (fwd.rd != '0);

  assign rs_mem_hit = mem_fwd_ok && (mem.rd == ex.rs_idx);
  assign rt_mem_hit = mem_fwd_ok && (mem.rd == ex.rt_idx);
  assign rs_wb_hit  = wb_fwd_ok && (fwd.rd == ex.rs_idx);
  assign rt_wb_hit  = wb_fwd_ok && (fwd.rd == ex.rt_idx);

  // nearest producer wins
  assign rs_val = rs_mem_hit ? mem.alu_result :
                  rs_wb_hit  ? fwd.data       : ex.rs_data;
  assign rt_val = rt_mem_hit ? mem.alu_result :
                  rt_wb_hit  ? fwd.data       : ex.rt_data;

  assign op_a  = rs_val;
  assign op_b  = ex.ctrl.use_imm ? ex.imm : rt_val;
  assign shamt = op_b[SHAMT_W-1:0];

  // doubled word so a right shift becomes a rotate
  assign rot_wide = {op_a, op_a} >> shamt;

  always_comb begin
    case (ex.ctrl.alu_op)
      // adds wrap and also form load and store addresses
      OP_ADD, OP_LW, OP_SW: alu_out = op_a + op_b;
      OP_SUB: alu_out = op_a - op_b;
      OP_XOR: alu_out = op_a ^ op_b;
      OP_SLL: alu_out = op_a << shamt;
      OP_SRA: alu_out = $signed(op_a) >>> shamt;
      OP_ROR: alu_out = rot_wide[`CPU_DATA_W-1:0];
      // keep high byte, replace low byte
      OP_LLB: alu_out = {op_a[`CPU_DATA_W-1:8], op_b[7:0]};
      // replace high byte, keep low byte
      OP_LHB: alu_out = {op_b[7:0], op_a[7:0]};
      // no-ops and hlt
      default: alu_out = '0;
    endcase
  end

  // execute/result slot
  always_ff @(posedge clk) begin
    if (reset) mem.valid <= 1'b0;
    else mem.valid <= ex.valid;
  end

  always_ff @(posedge clk) begin
    mem.ctrl       <= ex.ctrl;
    mem.rd         <= ex.rd;
    mem.alu_result <= alu_out;
    // store data follows the forwarded rt
    mem.store_data <= rt_val;
  end

endmodule

//--- source/fetch_decode.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_decode
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  output word_t   instr_addr,
  input  word_t   instr_data,
  output word_t   pc,
  wb_bus_if.write wb,
  ex_bus_if.src   ex
);

  word_t      pc_q;
  word_t      fetch_instr;
  logic       fetch_valid;
  logic       fetch_stop;
  logic       hlt_fetched;
  opcode_e    op;
  reg_idx_t   rd;
  reg_idx_t   rs;
  reg_idx_t   rt;
  word_t      imm;
  exec_ctrl_t ctrl;
  word_t      rs_rf;
  word_t      rt_rf;
  logic       is_shift;
  logic       is_mem;
  logic       is_byte;
  logic       writes_rd;

  assign instr_addr = pc_q;
  assign pc         = pc_q;

  // instruction port answers in the same cycle
  assign hlt_fetched = (instr_data[15:12] == OP_HLT);

  // pc steps by one instruction until a hlt is captured
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q        <= '0;
      fetch_valid <= 1'b0;
      fetch_stop  <= 1'b0;
    end else if (fetch_stop) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= 1'b1;
      if (hlt_fetched) fetch_stop <= 1'b1;
      else pc_q <= pc_q + `CPU_DATA_W'(2);
    end
  end

  always_ff @(posedge clk) begin
    if (!fetch_stop) fetch_instr <= instr_data;
  end

  // field decode
  assign op        = opcode_e'(fetch_instr[15:12]);
  assign is_shift  = op inside {OP_SLL, OP_SRA, OP_ROR};
  assign is_mem    = op inside {OP_LW, OP_SW};
  assign is_byte   = op inside {OP_LLB, OP_LHB};
  assign writes_rd = is_shift || is_byte ||
                     (op inside {OP_ADD, OP_SUB, OP_XOR, OP_LW});

  assign rd = fetch_instr[11:8];
  // byte loads merge into the old rd value
  assign rs = is_byte ? rd : fetch_instr[7:4];
  // store data register sits in the rd field
  assign rt = (op == OP_SW) ? fetch_instr[11:8] : fetch_instr[3:0];

  always_comb begin
    if (is_mem) begin
      // word offset turned into a byte offset
      imm = {{(`CPU_DATA_W-5){fetch_instr[3]}}, fetch_instr[3:0], 1'b0};
    end else if (is_byte) begin
      imm = {{(`CPU_DATA_W-8){1'b0}}, fetch_instr[7:0]};
    end else begin
      imm = {{(`CPU_DATA_W-4){1'b0}}, fetch_instr[3:0]};
    end
  end

  always_comb begin
    ctrl.alu_op    = op;
    ctrl.use_imm   = is_shift || is_mem || is_byte;
    ctrl.mem_write = (op == OP_SW);
    ctrl.mem_read  = (op == OP_LW);
    // writes to register 0 are dropped here
    ctrl.reg_write = writes_rd && (rd != '0);
    ctrl.halt      = (op == OP_HLT);
  end

  register_file i_register_file (
    .clk     (clk),
    .reset   (reset),
    .rs_idx  (rs),
    .rt_idx  (rt),
    .rs_data (rs_rf),
    .rt_data (rt_rf),
    .wb      (wb)
  );

  // decode/execute slot
  always_ff @(posedge clk) begin
    if (reset) ex.valid <= 1'b0;
    else ex.valid <= fetch_valid;
  end

  always_ff @(posedge clk) begin
    ex.ctrl    <= ctrl;
    ex.rs_idx  <= rs;
    ex.rt_idx  <= rt;
    ex.rd      <= rd;
    ex.rs_data <= rs_rf;
    ex.rt_data <= rt_rf;
    ex.imm     <= imm;
  end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs_idx,
  input  reg_idx_t rt_idx,
  output word_t    rs_data,
  output word_t    rt_data,
  wb_bus_if.write  wb
);

  word_t regs [`CPU_REG_COUNT];
  logic  wr_en;

  // only a live write to a real register lands
  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // register 0 pinned to zero
  // a write in flight this cycle is passed straight through
  function automatic word_t read_port(input reg_idx_t idx);
    word_t val;
    if (idx == '0) val = '0;
    else if (wr_en && (wb.rd == idx)) val = wb.data;
    else val = regs[idx];
    return val;
  endfunction

  // reevaluated on any register or write bus change
  always_comb begin
    rs_data = read_port(rs_idx);
    rt_data = read_port(rt_idx);
  end

endmodule

//--- source/cpu_if.sv
`timescale 1ns/1ps

// decode to execute slot
interface ex_bus_if
  import cpu_pkg::*;
();
  logic       valid;
  exec_ctrl_t ctrl;
  reg_idx_t   rs_idx;
  reg_idx_t   rt_idx;
  reg_idx_t   rd;
  word_t      rs_data;
  word_t      rt_data;
  word_t      imm;

  modport src (output valid, ctrl, rs_idx, rt_idx, rd, rs_data, rt_data, imm);
  modport dst (input valid, ctrl, rs_idx, rt_idx, rd, rs_data, rt_data, imm);
endinterface

// execute to result slot
interface mem_bus_if
  import cpu_pkg::*;
();
  logic       valid;
  exec_ctrl_t ctrl;
  reg_idx_t   rd;
  // alu result doubles as the data memory address
  word_t      alu_result;
  word_t      store_data;

  modport src (output valid, ctrl, rd, alu_result, store_data);
  modport dst (input valid, ctrl, rd, alu_result, store_data);
endinterface

// result to writeback slot
interface wb_bus_if
  import cpu_pkg::*;
();
  logic     valid;
  logic     reg_write;
  reg_idx_t rd;
  word_t    data;

  modport src (output valid, reg_write, rd, data);
  // register file write port
  modport write (input valid, reg_write, rd, data);
  // operand bypass into execute
  modport forward (input valid, reg_write, rd, data);
endinterface

//--- source/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  // one machine word
  typedef logic [`CPU_DATA_W-1:0] word_t;

  // register number
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

  // instruction opcodes in bits 15:12
  // values 3, 7, c, d and e are unnamed and act as no-ops
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_ROR = 4'h6,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_HLT = 4'hF
  } opcode_e;

  // controls produced by decode and consumed downstream
  typedef struct packed {
    opcode_e alu_op;
    // second alu operand comes from imm
    logic    use_imm;
    logic    mem_write;
    logic    mem_read;
    // already cleared when rd is register 0
    logic    reg_write;
    logic    halt;
  } exec_ctrl_t;

  // one register write as seen on the retire trace
  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
  } wb_rec_t;

  // one store as seen on the store trace
  typedef struct packed {
    // byte address
    word_t addr;
    word_t data;
  } store_rec_t;

endpackage

//--- source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and instruction word width
`define CPU_DATA_W 16

// architectural register count
`define CPU_REG_COUNT 16

// data memory depth in 16-bit words
`define CPU_DMEM_WORDS 256

`endif
